/* verilog.f */
design/ppu_regs_pkg.sv
design/ppu_timing_pkg.sv
design/ppu_ifs.sv
design/ppu_regs.sv
design/lcd_timing.sv
design/oam_dma.sv
design/oam_arbiter.sv
design/bg_fetcher.sv
design/pixel_shifter.sv
design/ppu_top.sv
testbench/tb_ppu.sv

/* testbench/tb_ppu.sv */
/*
  testbench for the background PPU with the LCD off tests first
  VRAM and DMA source are models that answer one clock after the address
  one whole frame is then checked dot by dot
  the run stops at the first error
*/
`timescale 1ns/1ns
`default_nettype none

module tb_ppu;
	import ppu_regs_pkg::*;
	import ppu_timing_pkg::*;

	localparam int FRAME_DOTS = DOTS_PER_LINE * LINES_PER_FRAME;
	// palette that swaps shades so mapping errors show up
	localparam byte_t TEST_BGP = 8'h1B;
	// LCD on, unsigned tile data, map at 9800, background on
	localparam byte_t TEST_LCDC = 8'h91;
	localparam int N_REG_ROWS = 11;
	// rows of {address, write data, expected readback} with the first row in the top bits
	localparam logic [N_REG_ROWS*24-1:0] REG_TABLE = {
		{ADDR_LCDC, 8'h11, 8'h11},
		{ADDR_SCY, 8'h12, 8'h12},
		{ADDR_SCX, 8'h34, 8'h34},
		{ADDR_LYC, 8'h05, 8'h05},
		// bit 7 always set, LYC enable, no match, mode 0
		{ADDR_STAT, 8'h40, 8'hC0},
		{ADDR_BGP, TEST_BGP, TEST_BGP},
		// LY is read only and sits at 0 with the LCD off
		{ADDR_LY, 8'h99, 8'h00},
		{8'h48, 8'h55, OPEN_BUS},
		{8'h3F, 8'h55, OPEN_BUS},
		// scroll back to 0 for the pixel check
		{ADDR_SCY, 8'h00, 8'h00},
		{ADDR_SCX, 8'h00, 8'h00}
	};

	logic clk;
	logic reset;
	logic cpu_sel_oam;
	logic cpu_sel_reg;
	reg_addr_t cpu_addr;
	logic cpu_wr;
	byte_t cpu_di;
	byte_t cpu_do;
	logic lcd_on;
	logic lcd_clkena;
	shade_t lcd_data;
	logic lcd_vsync;
	logic irq;
	logic vblank;
	ppu_mode_t mode;
	logic vram_rd;
	vram_addr_t vram_addr;
	byte_t vram_data;
	logic dma_rd;
	logic [15:0] dma_addr;
	byte_t dma_data;
	// addresses as seen mid cycle by the memory models
	vram_addr_t vram_addr_q;
	logic [15:0] dma_addr_q;

	ppu_top ppu_top_i (
		.clk(clk), .reset(reset),
		.cpu_sel_oam(cpu_sel_oam), .cpu_sel_reg(cpu_sel_reg), .cpu_addr(cpu_addr),
		.cpu_wr(cpu_wr), .cpu_di(cpu_di), .cpu_do(cpu_do),
		.lcd_on(lcd_on), .lcd_clkena(lcd_clkena), .lcd_data(lcd_data),
		.lcd_vsync(lcd_vsync), .irq(irq), .vblank(vblank), .mode(mode),
		.vram_rd(vram_rd), .vram_addr(vram_addr), .vram_data(vram_data),
		.dma_rd(dma_rd), .dma_addr(dma_addr), .dma_data(dma_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ----------------------------------------
	// memory models
	// ----------------------------------------
	// map entries hold A mod 4 and tile bytes hold D xor 5A
	function automatic byte_t vram_byte(input vram_addr_t a);
		if (a >= 13'h1800)
			return byte_t'(a % 4);
		else
			return a[7:0] ^ 8'h5A;
	endfunction

	always @(negedge clk) begin
		vram_addr_q = vram_addr;
		dma_addr_q = dma_addr;
	end

	// data for the address of the last cycle appears 1 ns after the edge
	always @(posedge clk) begin
		#1;
		vram_data = vram_byte(vram_addr_q);
		dma_data = dma_addr_q[7:0] + 8'd3;
	end

	// ----------------------------------------
	// checking helpers
	// ----------------------------------------
	task automatic stop_on_failure();
		$display("sim failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	// expected shade of pixel x on a tile row with unsigned tile data and the map at 9800
	function automatic shade_t bg_shade(input int x, input int row, input byte_t pal);
		vram_addr_t map_a;
		byte_t tile;
		vram_addr_t d;
		byte_t lo;
		byte_t hi;
		int b;
		int idx;
		map_a = 13'h1800 + vram_addr_t'(x / 8);
		tile = byte_t'(map_a % 4);
		d = vram_addr_t'(tile * 16 + row * 2);
		lo = d[7:0] ^ 8'h5A;
		hi = (d[7:0] | 8'h01) ^ 8'h5A;
		// leftmost pixel is bit 7
		b = 7 - (x % 8);
		idx = {hi[b], lo[b]};
		return pal[2 * idx +: 2];
	endfunction

	// ----------------------------------------
	// CPU bus
	// ----------------------------------------
	task automatic cpu_write(input logic to_oam, input reg_addr_t addr, input byte_t data);
		@(posedge clk);
		#1;
		cpu_sel_oam = to_oam;
		cpu_sel_reg = !to_oam;
		cpu_addr = addr;
		cpu_di = data;
		cpu_wr = 1'b1;
		@(posedge clk);
		#1;
		cpu_wr = 1'b0;
		cpu_sel_reg = 1'b0;
		cpu_sel_oam = 1'b0;
	endtask

	task automatic cpu_read(input logic from_oam, input reg_addr_t addr, output byte_t data);
		@(posedge clk);
		#1;
		cpu_sel_oam = from_oam;
		cpu_sel_reg = !from_oam;
		cpu_addr = addr;
		cpu_wr = 1'b0;
		// read path is combinational so the data is taken mid cycle
		@(negedge clk);
		data = cpu_do;
	endtask

	// LY is watched through the register read mux
	task automatic wait_line_mode(input int line, input logic [1:0] m, input int limit);
		int n;
		@(posedge clk);
		#1;
		cpu_sel_oam = 1'b0;
		cpu_sel_reg = 1'b0;
		cpu_addr = ADDR_LY;
		n = 0;
		@(negedge clk);
		while (cpu_do !== byte_t'(line) || mode !== m) begin
			n++;
			if (n > limit) begin
				$display("timeout while waiting for line %0d in mode %0d", line, m);
				stop_on_failure();
			end
			@(negedge clk);
		end
	endtask

	task automatic wait_dma_copy();
		int n;
		int busy;
		n = 0;
		@(negedge clk);
		while (dma_rd !== 1'b1) begin
			n++;
			if (n > 8) begin
				$display("DMA did not start after the write to the DMA register");
				stop_on_failure();
			end
			@(negedge clk);
		end
		busy = 0;
		while (dma_rd === 1'b1) begin
			check_value("dma_addr page", dma_addr[15:8], 8'h80);
			busy++;
			if (busy > 2 * OAM_BYTES * DMA_DOTS_PER_BYTE) begin
				$display("timeout while waiting for the DMA copy to finish");
				stop_on_failure();
			end
			@(negedge clk);
		end
		check_value("dma busy cycles", busy, OAM_BYTES * DMA_DOTS_PER_BYTE);
	endtask

	// ----------------------------------------
	// one frame right after the LCD is switched on
	// ----------------------------------------
	task automatic check_frame();
		int line;
		int dot;
		int pulses;
		logic draw_over;
		int n_addr;
		vram_addr_t seen [3];
		vram_addr_t exp_map;
		byte_t exp_tile;
		cpu_sel_oam = 1'b0;
		cpu_sel_reg = 1'b0;
		cpu_addr = ADDR_LY;
		n_addr = 0;
		for (line = 0; line < LINES_PER_FRAME; line++) begin
			pulses = 0;
			draw_over = 1'b0;
			for (dot = 0; dot < DOTS_PER_LINE; dot++) begin
				@(negedge clk);
				check_value("lcd_on", lcd_on, 1);
				check_value("ly", cpu_do, line);
				check_value("lcd_vsync", lcd_vsync, line == 0);
				check_value("vblank", vblank, line >= VISIBLE_LINES);
				// LYC compare lags by one dot
				if (dot != 0)
					check_value("irq", irq, line == 5);
				if (line >= VISIBLE_LINES) begin
					check_value("mode", mode, MODE_VBLANK);
				end else if (dot < OAM_SCAN_DOTS) begin
					check_value("mode", mode, MODE_OAM);
				end else if (dot == OAM_SCAN_DOTS) begin
					check_value("mode", mode, MODE_DRAW);
				end else if (!draw_over) begin
					if (mode === MODE_HBLANK)
						draw_over = 1'b1;
					else
						check_value("mode", mode, MODE_DRAW);
				end else begin
					check_value("mode", mode, MODE_HBLANK);
				end
				// VRAM is only read by the fetcher in mode 3
				if (mode !== MODE_DRAW)
					check_value("vram_rd", vram_rd, 0);
				if (lcd_clkena === 1'b1) begin
					check_value("mode during pixel", mode, MODE_DRAW);
					if (line == 0)
						check_value($sformatf("lcd_data x=%0d", pulses), lcd_data,
							bg_shade(pulses, 0, TEST_BGP));
					pulses++;
				end
				// first distinct VRAM addresses of the frame
				if (line == 0 && vram_rd === 1'b1 && n_addr < 3) begin
					if (n_addr == 0 || vram_addr !== seen[n_addr - 1]) begin
						seen[n_addr] = vram_addr;
						n_addr++;
					end
				end
			end
			if (line < VISIBLE_LINES) begin
				check_value("lcd_clkena pulses", pulses, SCREEN_WIDTH);
				check_value("mode 3 ended", draw_over, 1);
			end else begin
				check_value("lcd_clkena pulses", pulses, 0);
			end
		end
		// map entry for column 0 row 0 and then both bytes of that tile
		exp_map = 13'h1800;
		exp_tile = byte_t'(exp_map % 4);
		check_value("vram reads", n_addr, 3);
		check_value("map address", seen[0], exp_map);
		check_value("tile low address", seen[1], exp_tile * 16);
		check_value("tile high address", seen[2], exp_tile * 16 + 1);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin : main
		int r;
		int i;
		logic [23:0] row;
		byte_t rd;
		reset = 1'b1;
		cpu_sel_oam = 1'b0;
		cpu_sel_reg = 1'b0;
		cpu_addr = '0;
		cpu_wr = 1'b0;
		cpu_di = '0;
		vram_data = '0;
		dma_data = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		// outputs idle while the LCD is still off
		@(negedge clk);
		check_value("irq after reset", irq, 0);
		check_value("vblank after reset", vblank, 0);
		check_value("lcd_clkena after reset", lcd_clkena, 0);
		check_value("vram_rd after reset", vram_rd, 0);
		check_value("dma_rd after reset", dma_rd, 0);
		check_value("lcd_vsync after reset", lcd_vsync, 0);

		// register table with the LCD off
		for (r = 0; r < N_REG_ROWS; r++) begin
			row = REG_TABLE[(N_REG_ROWS - 1 - r) * 24 +: 24];
			cpu_write(1'b0, row[23:16], row[15:8]);
			cpu_read(1'b0, row[23:16], rd);
			check_value($sformatf("cpu_do reg %0h", row[23:16]), rd, row[7:0]);
		end

		// DMA from page 80 where each source byte is its address plus 3
		cpu_write(1'b0, ADDR_DMA, 8'h80);
		wait_dma_copy();
		for (i = 0; i < OAM_BYTES; i++) begin
			cpu_read(1'b1, reg_addr_t'(i), rd);
			check_value($sformatf("oam[%0d]", i), rd, (i + 3) % 256);
		end
		cpu_read(1'b1, reg_addr_t'(OAM_BYTES), rd);
		check_value("oam past the end", rd, OPEN_BUS);

		// timing, pixels and irq over one frame
		cpu_write(1'b0, ADDR_LCDC, TEST_LCDC);
		check_frame();

		// STAT bit 2 follows LY == LYC
		wait_line_mode(5, MODE_HBLANK, 2 * FRAME_DOTS);
		check_value("irq on line 5", irq, 1);
		cpu_read(1'b0, ADDR_STAT, rd);
		// 1, enables 1000, match, mode 00
		check_value("stat on line 5", rd, 8'hC4);
		wait_line_mode(6, MODE_HBLANK, 2 * DOTS_PER_LINE);
		check_value("irq on line 6", irq, 0);
		cpu_read(1'b0, ADDR_STAT, rd);
		check_value("stat on line 6", rd, 8'hC0);

		// OAM is locked for the CPU in modes 2 and 3
		wait_line_mode(10, MODE_OAM, 2 * FRAME_DOTS);
		cpu_write(1'b1, 8'd3, 8'hAA);
		cpu_read(1'b1, 8'd3, rd);
		check_value("oam read in mode 2", rd, OPEN_BUS);
		wait_line_mode(10, MODE_DRAW, 2 * DOTS_PER_LINE);
		cpu_write(1'b1, 8'd4, 8'h55);
		cpu_read(1'b1, 8'd4, rd);
		check_value("oam read in mode 3", rd, OPEN_BUS);
		wait_line_mode(10, MODE_HBLANK, 2 * DOTS_PER_LINE);
		// blocked writes left the DMA bytes in place
		cpu_read(1'b1, 8'd3, rd);
		check_value("oam[3] after locked write", rd, 8'd6);
		cpu_read(1'b1, 8'd4, rd);
		check_value("oam[4] after locked write", rd, 8'd7);
		cpu_write(1'b1, 8'd5, 8'h3C);
		cpu_read(1'b1, 8'd5, rd);
		check_value("oam[5] written in mode 0", rd, 8'h3C);

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

/* design/ppu_top.sv */
/*
  DMG background PPU, no sprites, no window, no CGB
  SCX bits 2:0 are ignored, scroll is in whole tiles
  vram_data and dma_data are expected one clock after the address
*/
`timescale 1ns/1ns
`default_nettype none

module ppu_top (
	input  logic clk,
	input  logic reset,
	// CPU access to registers and OAM
	input  logic cpu_sel_oam,
	input  logic cpu_sel_reg,
	input  ppu_regs_pkg::reg_addr_t cpu_addr,
	input  logic cpu_wr,
	input  ppu_regs_pkg::byte_t cpu_di,
	output ppu_regs_pkg::byte_t cpu_do,
	// LCD side
	output logic lcd_on,
	output logic lcd_clkena,
	output ppu_timing_pkg::shade_t lcd_data,
	output logic lcd_vsync,
	output logic irq,
	output logic vblank,
	output ppu_timing_pkg::ppu_mode_t mode,
	// VRAM, read only
	output logic vram_rd,
	output ppu_timing_pkg::vram_addr_t vram_addr,
	input  ppu_regs_pkg::byte_t vram_data,
	// OAM DMA source
	output logic dma_rd,
	output logic [15:0] dma_addr,
	input  ppu_regs_pkg::byte_t dma_data
);
	import ppu_regs_pkg::*;
	import ppu_timing_pkg::*;

	line_t ly;
	logic lyc_match_l;
	byte_t lyc;
	byte_t stat_en;
	logic dma_start;
	byte_t dma_page;
	logic oam_lock;
	logic draw;
	logic draw_done;

	ppu_cfg_if cfg ();
	oam_port_if dma_oam ();
	oam_port_if cpu_oam ();
	tile_credit_if tiles ();

	assign lcd_on = cfg.lcd_on;

	ppu_regs ppu_regs_i (
		.clk(clk), .reset(reset),
		.cpu_sel_reg(cpu_sel_reg), .cpu_addr(cpu_addr), .cpu_wr(cpu_wr),
		.cpu_di(cpu_di), .cpu_sel_oam(cpu_sel_oam), .cpu_do(cpu_do),
		.cfg(cfg), .oam(cpu_oam),
		.ly(ly), .lyc_match_l(lyc_match_l), .mode(mode),
		.lyc(lyc), .stat_en(stat_en),
		.dma_start(dma_start), .dma_page(dma_page)
	);

	lcd_timing lcd_timing_i (
		.clk(clk), .cfg(cfg), .draw_done(draw_done),
		.lyc(lyc), .stat_en(stat_en),
		.ly(ly), .mode(mode), .lyc_match_l(lyc_match_l), .oam_lock(oam_lock),
		.draw(draw), .irq(irq), .vblank(vblank), .lcd_vsync(lcd_vsync)
	);

	oam_dma oam_dma_i (
		.clk(clk), .reset(reset),
		.dma_start(dma_start), .dma_page(dma_page),
		.dma_rd(dma_rd), .dma_addr(dma_addr), .dma_data(dma_data),
		.oam(dma_oam)
	);

	oam_arbiter oam_arbiter_i (
		.clk(clk), .dma_oam(dma_oam), .cpu_oam(cpu_oam), .oam_lock(oam_lock)
	);

	bg_fetcher bg_fetcher_i (
		.clk(clk), .cfg(cfg), .draw(draw), .ly(ly),
		.vram_rd(vram_rd), .vram_addr(vram_addr), .vram_data(vram_data),
		.tiles(tiles)
	);

	pixel_shifter pixel_shifter_i (
		.clk(clk), .cfg(cfg), .draw(draw), .tiles(tiles),
		.draw_done(draw_done), .lcd_clkena(lcd_clkena), .lcd_data(lcd_data)
	);

endmodule

`default_nettype wire

/* design/pixel_shifter.sv */
/*
  one tile buffer in front of two 8 bit shift registers
  one pixel per dot while bits remain, stalls when starved
  lcd_data is only meaningful while lcd_clkena is high
*/
`timescale 1ns/1ns
`default_nettype none

module pixel_shifter (
	input  logic clk,
	ppu_cfg_if.sink cfg,
	input  logic draw,
	tile_credit_if.sink tiles,
	output logic draw_done,
	output logic lcd_clkena,
	output ppu_timing_pkg::shade_t lcd_data
);
	import ppu_regs_pkg::*;
	import ppu_timing_pkg::*;

	byte_t buf_lo;
	byte_t buf_hi;
	logic buf_valid;
	byte_t sr_lo;
	byte_t sr_hi;
	logic [3:0] shift_cnt;
	logic [7:0] pix_cnt;
	logic load;
	logic [1:0] color_idx;

	// refill when empty or on the last pixel, keeps output gapless
	assign load = draw && buf_valid && (shift_cnt <= 4'd1);
	assign tiles.credit = load;

	always_ff @(posedge clk) begin
		if (!draw) begin
			buf_valid <= 1'b0;
			shift_cnt <= '0;
			pix_cnt <= '0;
		end else begin
			if (tiles.push) begin
				buf_lo <= tiles.lo;
				buf_hi <= tiles.hi;
				buf_valid <= 1'b1;
			end
			if (lcd_clkena)
				pix_cnt <= pix_cnt + 8'd1;
			if (load) begin
				sr_lo <= buf_lo;
				sr_hi <= buf_hi;
				shift_cnt <= 4'd8;
				buf_valid <= 1'b0;
			end else if (lcd_clkena) begin
				sr_lo <= sr_lo << 1;
				sr_hi <= sr_hi << 1;
				shift_cnt <= shift_cnt - 4'd1;
			end
		end
	end

	// ----------------------------------------
	// palette and LCD output
	// ----------------------------------------
	assign lcd_clkena = draw && (shift_cnt != 4'd0);
	// leftmost pixel is the MSB of both planes
	assign color_idx = cfg.bg_ena ? {sr_hi[7], sr_lo[7]} : 2'b00;
	assign lcd_data = cfg.bgp[{color_idx, 1'b0} +: 2];

	// ends mode 3 on the following dot
	assign draw_done = lcd_clkena && (pix_cnt == 8'(SCREEN_WIDTH - 1));

	assert property (@(posedge clk) lcd_clkena |-> (pix_cnt < 8'(SCREEN_WIDTH)));

endmodule

`default_nettype wire

/* design/bg_fetcher.sv */
/*
  background tile fetch of the map, low and high byte in turn
  each VRAM read takes two dots with the data sampled on the second
  a finished tile waits in PH_PUSH until the credit is held
*/
`timescale 1ns/1ns
`default_nettype none

module bg_fetcher (
	input  logic clk,
	ppu_cfg_if.sink cfg,
	input  logic draw,
	input  ppu_timing_pkg::line_t ly,
	output logic vram_rd,
	output ppu_timing_pkg::vram_addr_t vram_addr,
	input  ppu_regs_pkg::byte_t vram_data,
	tile_credit_if.source tiles
);
	import ppu_regs_pkg::*;
	import ppu_timing_pkg::*;

	typedef enum logic [1:0] {PH_MAP, PH_LO, PH_HI, PH_PUSH} phase_t;

	phase_t phase;
	// second dot of the current read
	logic second;
	logic credit_q;
	logic [4:0] col;
	byte_t tile_num;
	byte_t lo_q;
	byte_t hi_q;
	line_t bg_line;
	logic [4:0] map_col;
	logic a12;

	assign bg_line = ly + cfg.scy;
	// SCX 2:0 are dropped so scroll is coarse only
	assign map_col = col + cfg.scx[7:3];
	// in 8800 mode tiles 0..127 sit at 9000
	assign a12 = !cfg.tile_data_sel && !tile_num[7];

	always_ff @(posedge clk) begin
		if (!draw) begin
			// the credit for the next line is granted while idle between lines
			phase <= PH_MAP;
			second <= 1'b0;
			col <= '0;
			credit_q <= 1'b1;
		end else begin
			if (tiles.credit)
				credit_q <= 1'b1;
			if (phase != PH_PUSH)
				second <= !second;
			case (phase)
				PH_MAP: if (second) begin
					tile_num <= vram_data;
					phase <= PH_LO;
				end
				PH_LO: if (second) begin
					lo_q <= vram_data;
					phase <= PH_HI;
				end
				PH_HI: if (second) begin
					hi_q <= vram_data;
					phase <= PH_PUSH;
				end
				default: if (credit_q) begin
					// push spends the credit
					credit_q <= 1'b0;
					col <= col + 5'd1;
					phase <= PH_MAP;
				end
			endcase
		end
	end

	always_comb begin
		case (phase)
			PH_MAP:  vram_addr = {2'b11, cfg.bg_map_sel, bg_line[7:3], map_col};
			PH_LO:   vram_addr = {a12, tile_num, bg_line[2:0], 1'b0};
			default: vram_addr = {a12, tile_num, bg_line[2:0], 1'b1};
		endcase
	end

	// no access while waiting for the shifter
	assign vram_rd = draw && (phase != PH_PUSH);

	assign tiles.push = draw && (phase == PH_PUSH) && credit_q;
	assign tiles.lo = lo_q;
	assign tiles.hi = hi_q;

	// the shifter never returns a credit that is already held
	assert property (@(posedge clk) tiles.credit |-> !credit_q);

endmodule

`default_nettype wire

/* design/oam_arbiter.sv */
/*
  160 byte OAM shared by DMA and CPU
  DMA always wins, CPU is also shut out while OAM is locked
  CPU addresses FEA0 and up read open bus and ignore writes
*/
`timescale 1ns/1ns
`default_nettype none

module oam_arbiter (
	input  logic clk,
	oam_port_if.slave dma_oam,
	oam_port_if.slave cpu_oam,
	input  logic oam_lock
);
	import ppu_regs_pkg::*;
	import ppu_timing_pkg::*;

	byte_t ram [OAM_BYTES];
	logic cpu_hit;
	logic cpu_gnt;
	logic dma_wr;
	logic cpu_wr;

	assign cpu_hit = (cpu_oam.addr < OAM_BYTES);

	// grant is decided in the cycle of the request, nothing queues
	assign cpu_gnt = cpu_oam.req && !dma_oam.req && !oam_lock;
	assign dma_wr = dma_oam.req && dma_oam.we;
	assign cpu_wr = cpu_gnt && cpu_oam.we && cpu_hit;

	always_ff @(posedge clk) begin
		if (dma_wr)
			ram[dma_oam.addr] <= dma_oam.wdata;
		else if (cpu_wr)
			ram[cpu_oam.addr] <= cpu_oam.wdata;
	end

	// combinational read ports
	assign dma_oam.rdata = ram[dma_oam.addr];
	assign cpu_oam.rdata = (cpu_gnt && cpu_hit) ? ram[cpu_oam.addr] : OPEN_BUS;

	assert property (@(posedge clk) dma_wr |-> !cpu_wr);

endmodule

`default_nettype wire

/* design/oam_dma.sv */
/*
  OAM DMA, 160 bytes from page XX00 in 640 dots
  a new start restarts the copy from byte 0
*/
`timescale 1ns/1ns
`default_nettype none

module oam_dma (
	input  logic clk,
	input  logic reset,
	input  logic dma_start,
	input  ppu_regs_pkg::byte_t dma_page,
	output logic dma_rd,
	output logic [15:0] dma_addr,
	input  ppu_regs_pkg::byte_t dma_data,
	oam_port_if.master oam
);
	import ppu_timing_pkg::*;

	logic active;
	// bits 9:2 are the byte index, 1:0 the slot inside it
	logic [9:0] cnt;
	logic wr_slot;

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			cnt <= '0;
		end else if (dma_start) begin
			active <= 1'b1;
			cnt <= '0;
		end else if (active) begin
			if (cnt == 10'(OAM_BYTES * DMA_DOTS_PER_BYTE - 1))
				active <= 1'b0;
			else
				cnt <= cnt + 10'd1;
		end
	end

	// third slot of each byte, source data has settled by then
	assign wr_slot = active && (cnt[1:0] == 2'(DMA_DOTS_PER_BYTE - 2));

	assign dma_rd = active;
	assign dma_addr = {dma_page, cnt[9:2]};

	// holding req for the whole copy keeps the CPU out of OAM
	assign oam.req = active;
	assign oam.we = wr_slot;
	assign oam.addr = oam_addr_t'(cnt[9:2]);
	assign oam.wdata = dma_data;

endmodule

`default_nettype wire

/* design/lcd_timing.sv */
/*
  dot and line counters, held at zero while the LCD is off
  mode 3 length is set by the shifter through draw_done
  the STAT interrupt is level sensitive, no edge detect
*/
`timescale 1ns/1ns
`default_nettype none

module lcd_timing (
	input  logic clk,
	ppu_cfg_if.sink cfg,
	input  logic draw_done,
	input  ppu_regs_pkg::byte_t lyc,
	input  ppu_regs_pkg::byte_t stat_en,
	output ppu_timing_pkg::line_t ly,
	output ppu_timing_pkg::ppu_mode_t mode,
	output logic lyc_match_l,
	output logic oam_lock,
	output logic draw,
	output logic irq,
	output logic vblank,
	output logic lcd_vsync
);
	import ppu_regs_pkg::*;
	import ppu_timing_pkg::*;

	dot_t h_cnt;
	line_t v_cnt;
	logic line_end;
	logic visible;

	assign line_end = (h_cnt == dot_t'(DOTS_PER_LINE - 1));
	assign visible = (v_cnt < line_t'(VISIBLE_LINES));

	always_ff @(posedge clk) begin
		if (!cfg.lcd_on) begin
			h_cnt <= '0;
			v_cnt <= '0;
			draw <= 1'b0;
		end else begin
			if (line_end) begin
				h_cnt <= '0;
				v_cnt <= (v_cnt == line_t'(LINES_PER_FRAME - 1)) ? '0 : v_cnt + 8'd1;
			end else begin
				h_cnt <= h_cnt + 9'd1;
			end
			// drawing opens on the dot after the OAM scan
			if (visible && h_cnt == dot_t'(OAM_SCAN_DOTS - 1))
				draw <= 1'b1;
			else if (draw_done || line_end)
				draw <= 1'b0;
		end
	end

	// compare result lags LY by one dot
	always_ff @(posedge clk) begin
		lyc_match_l <= (v_cnt == lyc);
	end

	always_comb begin
		if (!cfg.lcd_on)
			mode = MODE_HBLANK;
		else if (!visible)
			mode = MODE_VBLANK;
		else if (h_cnt < dot_t'(OAM_SCAN_DOTS))
			mode = MODE_OAM;
		else if (draw)
			mode = MODE_DRAW;
		else
			mode = MODE_HBLANK;
	end

	// CPU loses OAM while the scan or the draw would use it
	assign oam_lock = (mode == MODE_OAM) || (mode == MODE_DRAW);

	assign irq = (stat_en[STAT_INT_LYC] && lyc_match_l) ||
		(stat_en[STAT_INT_OAM] && mode == MODE_OAM) ||
		(stat_en[STAT_INT_VBL] && mode == MODE_VBLANK) ||
		(stat_en[STAT_INT_HBL] && mode == MODE_HBLANK && visible && cfg.lcd_on);

	assign ly = v_cnt;
	assign vblank = !visible;
	assign lcd_vsync = cfg.lcd_on && (v_cnt == '0);

	// the wrap at the last line must never be skipped
	assert property (@(posedge clk) line_end |=> (v_cnt < line_t'(LINES_PER_FRAME)));

endmodule

`default_nettype wire

/* design/ppu_regs.sv */
/*
  register block at FF40..FF47, reads are combinational
  LY writes are ignored, STAT keeps only its enable bits
  DMA starts the cycle after the write to FF46
*/
`timescale 1ns/1ns
`default_nettype none

module ppu_regs (
	input  logic clk,
	input  logic reset,
	input  logic cpu_sel_reg,
	input  ppu_regs_pkg::reg_addr_t cpu_addr,
	input  logic cpu_wr,
	input  ppu_regs_pkg::byte_t cpu_di,
	input  logic cpu_sel_oam,
	output ppu_regs_pkg::byte_t cpu_do,
	ppu_cfg_if.source cfg,
	oam_port_if.master oam,
	input  ppu_timing_pkg::line_t ly,
	input  logic lyc_match_l,
	input  ppu_timing_pkg::ppu_mode_t mode,
	output ppu_regs_pkg::byte_t lyc,
	output ppu_regs_pkg::byte_t stat_en,
	output logic dma_start,
	output ppu_regs_pkg::byte_t dma_page
);
	import ppu_regs_pkg::*;

	byte_t lcdc;
	byte_t scy;
	byte_t scx;
	byte_t bgp;
	logic reg_wr;

	assign reg_wr = cpu_sel_reg && cpu_wr;

	// ----------------------------------------
	// write decode
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			// LCD starts off so boot code can fill VRAM
			lcdc <= '0;
			stat_en <= '0;
			scy <= '0;
			scx <= '0;
			lyc <= '0;
			dma_page <= '0;
			bgp <= BGP_RESET;
			dma_start <= 1'b0;
		end else begin
			// one cycle pulse, page register is already updated then
			dma_start <= reg_wr && (cpu_addr == ADDR_DMA);
			if (reg_wr) begin
				case (cpu_addr)
					ADDR_LCDC: lcdc <= cpu_di;
					// mode and match bits are read only
					ADDR_STAT: stat_en <= cpu_di & 8'h78;
					ADDR_SCY:  scy <= cpu_di;
					ADDR_SCX:  scx <= cpu_di;
					ADDR_LYC:  lyc <= cpu_di;
					ADDR_DMA:  dma_page <= cpu_di;
					ADDR_BGP:  bgp <= cpu_di;
					default: ;
				endcase
			end
		end
	end

	// ----------------------------------------
	// read mux
	// ----------------------------------------
	always_comb begin
		if (cpu_sel_oam) begin
			// arbiter already returns open bus when locked
			cpu_do = oam.rdata;
		end else begin
			case (cpu_addr)
				ADDR_LCDC: cpu_do = lcdc;
				ADDR_STAT: cpu_do = {1'b1, stat_en[STAT_INT_LYC:STAT_INT_HBL], lyc_match_l, mode};
				ADDR_SCY:  cpu_do = scy;
				ADDR_SCX:  cpu_do = scx;
				ADDR_LY:   cpu_do = ly;
				ADDR_LYC:  cpu_do = lyc;
				ADDR_DMA:  cpu_do = dma_page;
				ADDR_BGP:  cpu_do = bgp;
				default:   cpu_do = OPEN_BUS;
			endcase
		end
	end

	// CPU side of the OAM arbiter
	assign oam.req = cpu_sel_oam;
	assign oam.we = cpu_wr;
	assign oam.addr = cpu_addr;
	assign oam.wdata = cpu_di;

	// fields the rest of the PPU looks at
	assign cfg.lcd_on = lcdc[LCDC_ON];
	assign cfg.bg_map_sel = lcdc[LCDC_BG_MAP_SEL];
	assign cfg.tile_data_sel = lcdc[LCDC_TILE_DATA_SEL];
	assign cfg.bg_ena = lcdc[LCDC_BG_ENA];
	assign cfg.scx = scx;
	assign cfg.scy = scy;
	assign cfg.bgp = bgp;

endmodule

`default_nettype wire

/* design/ppu_ifs.sv */
/*
  bundles used between the PPU blocks
  OAM ports are served in the cycle of the request
  the tile link carries exactly one credit per line
*/
`timescale 1ns/1ns
`default_nettype none

// one requester of the shared OAM store
interface oam_port_if;
	import ppu_regs_pkg::*;
	import ppu_timing_pkg::*;

	logic req;
	logic we;
	oam_addr_t addr;
	byte_t wdata;
	byte_t rdata;

	modport master (output req, we, addr, wdata, input rdata);
	modport slave (input req, we, addr, wdata, output rdata);
endinterface

// fetcher to shifter, one tile row per push
interface tile_credit_if;
	import ppu_regs_pkg::*;

	logic push;
	byte_t lo;
	byte_t hi;
	// pulsed by the shifter when its buffer frees up
	logic credit;

	modport source (output push, lo, hi, input credit);
	modport sink (input push, lo, hi, output credit);
endinterface

// register fields that steer timing, fetch and palette
interface ppu_cfg_if;
	import ppu_regs_pkg::*;

	logic lcd_on;
	logic bg_map_sel;
	logic tile_data_sel;
	logic bg_ena;
	byte_t scx;
	byte_t scy;
	byte_t bgp;

	modport source (output lcd_on, bg_map_sel, tile_data_sel, bg_ena, scx, scy, bgp);
	modport sink (input lcd_on, bg_map_sel, tile_data_sel, bg_ena, scx, scy, bgp);
endinterface

`default_nettype wire

/* design/ppu_timing_pkg.sv */
/*
  line, frame and fetch geometry of the DMG picture processor
  one clock is one dot, no clock enables anywhere
*/
`default_nettype none

package ppu_timing_pkg;

	typedef logic [8:0] dot_t;
	typedef logic [7:0] line_t;
	typedef logic [7:0] oam_addr_t;
	typedef logic [12:0] vram_addr_t;
	typedef logic [1:0] shade_t;

	// ----------------------------------------
	// frame geometry
	// ----------------------------------------
	localparam int unsigned DOTS_PER_LINE   = 456;
	localparam int unsigned LINES_PER_FRAME = 154;
	localparam int unsigned VISIBLE_LINES   = 144;

	// mode 2 length, mode 3 starts right after
	localparam int unsigned OAM_SCAN_DOTS = 80;

	// pixels output per visible line
	localparam int unsigned SCREEN_WIDTH = 160;

	// ----------------------------------------
	// OAM and DMA
	// ----------------------------------------
	localparam int unsigned OAM_BYTES = 160;

	// one OAM byte copied every four dots
	localparam int unsigned DMA_DOTS_PER_BYTE = 4;

	// encoding as read back in STAT bits 1:0
	typedef enum logic [1:0] {
		MODE_HBLANK = 2'd0,
		MODE_VBLANK = 2'd1,
		MODE_OAM    = 2'd2,
		MODE_DRAW   = 2'd3
	} ppu_mode_t;

endpackage

`default_nettype wire

/* design/ppu_regs_pkg.sv */
/*
  CPU side register map of the DMG background PPU
  only the low address byte is decoded, FF40 to FF47
*/
`default_nettype none

package ppu_regs_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [7:0] reg_addr_t;

	// register addresses, low byte of FFxx
	localparam reg_addr_t ADDR_LCDC = 8'h40;
	localparam reg_addr_t ADDR_STAT = 8'h41;
	localparam reg_addr_t ADDR_SCY  = 8'h42;
	localparam reg_addr_t ADDR_SCX  = 8'h43;
	localparam reg_addr_t ADDR_LY   = 8'h44;
	localparam reg_addr_t ADDR_LYC  = 8'h45;
	localparam reg_addr_t ADDR_DMA  = 8'h46;
	localparam reg_addr_t ADDR_BGP  = 8'h47;

	// shades 3,3,3,0 for indices 3..0
	localparam byte_t BGP_RESET = 8'hFC;

	// LCDC bits that survive in DMG background-only mode
	localparam int unsigned LCDC_ON            = 7;
	localparam int unsigned LCDC_TILE_DATA_SEL = 4;
	localparam int unsigned LCDC_BG_MAP_SEL    = 3;
	localparam int unsigned LCDC_BG_ENA        = 0;

	// STAT interrupt source enables
	localparam int unsigned STAT_INT_LYC = 6;
	localparam int unsigned STAT_INT_OAM = 5;
	localparam int unsigned STAT_INT_VBL = 4;
	localparam int unsigned STAT_INT_HBL = 3;

	// seen by the CPU on unmapped or locked reads
	localparam byte_t OPEN_BUS = 8'hFF;

endpackage

`default_nettype wire
